//--- bench/tb_programs.svh
// Per-thread program words and the writebacks each program should produce
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

typedef struct packed {
  logic [1:0]  tid;
  logic [5:0]  offset;
  logic [31:0] instr;
} stim_entry_t;

typedef struct packed {
  logic [4:0]  rd;
  logic [31:0] value;
} exp_entry_t;

localparam int MAX_STIM = 128;
localparam int MAX_EXP  = 32;

stim_entry_t stim_tab [MAX_STIM];
int          stim_len;
exp_entry_t  exp_tab [4][MAX_EXP];
int          exp_len [4];
int          prog_len [4];
int          seed = 32'hc5d629b0;

// ==================================================
// Instruction encoders
// ==================================================
function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, mt_pkg::OP_OP};
endfunction

function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, mt_pkg::OP_IMM};
endfunction

function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, mt_pkg::OP_LUI};
endfunction

// Appends one program word and its expected writeback unless rd is zero
task automatic push_instr(input int t, input logic [31:0] instr, input logic [4:0] rd,
                          input logic [31:0] value);
  stim_tab[stim_len] = '{tid: 2'(t), offset: 6'(prog_len[t]), instr: instr};
  stim_len++;
  prog_len[t]++;
  if (rd != 5'd0) begin
    exp_tab[t][exp_len[t]] = '{rd: rd, value: value};
    exp_len[t]++;
  end
endtask

// ==================================================
// Program set
// ==================================================
// Every thread uses the same register numbers with its own values
task automatic build_programs();
  logic [31:0] x1;
  logic [31:0] x2;
  logic [31:0] x3;
  logic [31:0] rnd;
  logic [11:0] imm;
  logic [4:0]  sh;
  stim_len = 0;
  for (int t = 0; t < 4; t++) begin
    exp_len[t]  = 0;
    prog_len[t] = 0;
  end
  for (int t = 0; t < 4; t++) begin
    // Negative x1 from LUI plus a negative add-immediate
    x1 = {20'hffff0 + 20'(t), 12'h000};
    push_instr(t, lui_word(20'hffff0 + 20'(t), 5'd1), 5'd1, x1);
    imm = 12'(-(t + 5));
    x1  = x1 + {{20{imm[11]}}, imm};
    push_instr(t, itype_word(imm, 5'd1, 3'b000, 5'd1), 5'd1, x1);
    x2 = 32'(100 + 17 * t);
    push_instr(t, itype_word(12'(100 + 17 * t), 5'd0, 3'b000, 5'd2), 5'd2, x2);
    x3 = 32'(3 + t);
    push_instr(t, itype_word(12'(3 + t), 5'd0, 3'b000, 5'd3), 5'd3, x3);

    push_instr(t, rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, x1 + x2);
    push_instr(t, rtype_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd5), 5'd5, x2 - x1);
    push_instr(t, rtype_word(7'h00, 5'd3, 5'd2, 3'b001, 5'd6), 5'd6, x2 << x3);
    // Negative x1 and positive x2 make signed and unsigned order disagree
    push_instr(t, rtype_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd7), 5'd7, 32'd1);
    push_instr(t, rtype_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd19), 5'd19, 32'd0);
    push_instr(t, rtype_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd8), 5'd8, 32'd0);
    push_instr(t, rtype_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd18), 5'd18, 32'd1);
    push_instr(t, rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd9), 5'd9, x1 ^ x2);
    push_instr(t, rtype_word(7'h00, 5'd3, 5'd1, 3'b101, 5'd10), 5'd10, x1 >> x3);
    // Arithmetic shift of a negative value fills with ones
    push_instr(t, rtype_word(7'h20, 5'd3, 5'd1, 3'b101, 5'd11), 5'd11, ~(~x1 >> x3));
    push_instr(t, rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd12), 5'd12, x1 | x2);
    push_instr(t, rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd13), 5'd13, x1 & x2);

    sh = 5'(4 + t);
    push_instr(t, itype_word({7'b0100000, sh}, 5'd1, 3'b101, 5'd14), 5'd14, ~(~x1 >> sh));
    push_instr(t, itype_word(12'hfff, 5'd1, 3'b010, 5'd15), 5'd15, 32'd1);
    rnd = $random(seed);
    imm = rnd[11:0];
    push_instr(t, itype_word(imm, 5'd2, 3'b000, 5'd16), 5'd16, x2 + {{20{imm[11]}}, imm});

    // A write to x0 is dropped and x0 then reads back as zero
    push_instr(t, itype_word(12'd5, 5'd2, 3'b000, 5'd0), 5'd0, 32'd0);
    push_instr(t, rtype_word(7'h00, 5'd2, 5'd0, 3'b000, 5'd17), 5'd17, x2);
  end
endtask

`endif

//--- bench/tb_barrel_core.sv
// Testbench for the barrel core that loads per-thread programs and checks every writeback
`timescale 1ns/1ps
`default_nettype none

module tb_barrel_core;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 16;
  localparam int REGION_WORDS  = 64;
  localparam int HS_LIMIT      = 20;
  localparam int IDLE_CYCLES   = 8;
  localparam int DRAIN_CYCLES  = 16;
  localparam int MARGIN_CYCLES = 64;

  logic          clk;
  logic          rst;
  logic          run_i;
  mt_pkg::load_t load_i;
  logic          load_req_i;
  logic          load_ack_o;
  mt_pkg::wb_t   wb_o;
  logic          wb_valid_o;

  int         value_errors;
  int         protocol_errors;
  int         cycle_count = 0;
  int         cycle_limit = 0;
  int         checked;
  int         exp_total;
  int         exp_idx [4];
  logic       prev_valid;
  logic [1:0] prev_tid;

  `include "tb_programs.svh"

  barrel_core_top #(
    .NUM_THREADS         (mt_pkg::NUM_THREADS),
    .THREAD_REGION_WORDS (REGION_WORDS)
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .run_i      (run_i),
    .load_i     (load_i),
    .load_req_i (load_req_i),
    .load_ack_o (load_ack_o),
    .wb_o       (wb_o),
    .wb_valid_o (wb_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==================================================
  // Run end and timeout
  // ==================================================
  task automatic finish_run();
    $display("Error counts: value %0d, protocol %0d, writebacks checked %0d of %0d",
             value_errors, protocol_errors, checked, exp_total);
    if (value_errors == 0 && protocol_errors == 0 && checked == exp_total) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run stopped at the cycle limit with %0d of %0d writebacks still unchecked",
               exp_total - checked, exp_total);
      protocol_errors++;
      finish_run();
    end
  end

  // ==================================================
  // Load port
  // ==================================================
  // Four-phase handshake with req held one edge past ack before it drops
  task automatic load_word(input stim_entry_t entry);
    int waited;
    load_i.addr = mt_pkg::imem_addr_t'(entry.tid * REGION_WORDS + entry.offset);
    load_i.data = entry.instr;
    load_req_i  = 1'b1;
    waited      = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!load_ack_o && waited < HS_LIMIT);
    assert (load_ack_o) else begin
      $display("load_ack_o never rose for load address %h", load_i.addr);
      protocol_errors++;
    end
    @(negedge clk);
    load_req_i = 1'b0;
    waited     = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (load_ack_o && waited < HS_LIMIT);
    assert (!load_ack_o) else begin
      $display("load_ack_o never fell after load_req_i dropped for address %h", load_i.addr);
      protocol_errors++;
    end
  endtask

  // ==================================================
  // Writeback checker
  // ==================================================
  always @(negedge clk) begin : wb_checker
    int t;
    if (rst) begin
      prev_valid = 1'b0;
    end else begin
      if (wb_valid_o) begin
        t = wb_o.tid;
        assert (run_i) else begin
          $display("A writeback appeared while run_i was low");
          protocol_errors++;
        end
        assert (exp_idx[t] < exp_len[t]) else begin
          $display("Thread %0d wrote back more results than its program holds", t);
          protocol_errors++;
        end
        if (exp_idx[t] < exp_len[t]) begin
          assert (wb_o.rd == exp_tab[t][exp_idx[t]].rd) else begin
            $display("[ERROR] wb_o.rd: got %h, expected %h (thread %0d, entry %0d)",
                     wb_o.rd, exp_tab[t][exp_idx[t]].rd, t, exp_idx[t]);
            value_errors++;
          end
          assert (wb_o.data == exp_tab[t][exp_idx[t]].value) else begin
            $display("[ERROR] wb_o.data: got %h, expected %h (thread %0d, entry %0d)",
                     wb_o.data, exp_tab[t][exp_idx[t]].value, t, exp_idx[t]);
            value_errors++;
          end
          exp_idx[t]++;
          checked++;
        end
        // Back-to-back writebacks must step through the threads in order
        if (prev_valid) begin
          assert (wb_o.tid == 2'(prev_tid + 2'd1)) else begin
            $display("[ERROR] wb_o.tid: got %h, expected %h", wb_o.tid, 2'(prev_tid + 2'd1));
            value_errors++;
          end
        end
      end
      prev_valid = wb_valid_o;
      prev_tid   = wb_o.tid;
    end
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int max_len;
    rst             = 1'b1;
    run_i           = 1'b0;
    load_i          = '0;
    load_req_i      = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    checked         = 0;
    exp_total       = 0;
    max_len         = 0;
    build_programs();
    for (int t = 0; t < 4; t++) begin
      exp_idx[t] = 0;
      exp_total += exp_len[t];
      if (prog_len[t] > max_len) begin
        max_len = prog_len[t];
      end
    end
    cycle_limit = RESET_CYCLES + 6 * stim_len + IDLE_CYCLES + 4 * max_len + MARGIN_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (load_ack_o == 1'b0) else begin
      $display("[ERROR] load_ack_o after reset: got %h, expected %h", load_ack_o, 1'b0);
      value_errors++;
    end
    assert (wb_valid_o == 1'b0) else begin
      $display("[ERROR] wb_valid_o after reset: got %h, expected %h", wb_valid_o, 1'b0);
      value_errors++;
    end

    for (int i = 0; i < stim_len; i++) begin
      load_word(stim_tab[i]);
    end

    // Programs are in place and the core must stay quiet until run_i rises
    repeat (IDLE_CYCLES) @(negedge clk);
    run_i = 1'b1;
    while (checked < exp_total) begin
      @(negedge clk);
    end
    // Threads fall into NOP fill where any further writeback is flagged
    repeat (DRAIN_CYCLES) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

//--- design/alu.sv
// RV32I integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire mt_pkg::alu_op_e op_i,
  input  wire mt_pkg::word_t   a_i,
  input  wire mt_pkg::word_t   b_i,
  output mt_pkg::word_t        y_o
);

  logic [4:0]    shamt;
  logic          lt_signed;
  logic          lt_unsigned;
  mt_pkg::word_t sra_val;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;
  assign sra_val     = $signed(a_i) >>> shamt;

  always_comb begin
    case (op_i)
      mt_pkg::ADD:    y_o = a_i + b_i;
      mt_pkg::SUB:    y_o = a_i - b_i;
      mt_pkg::SLL:    y_o = a_i << shamt;
      mt_pkg::SLT:    y_o = {31'b0, lt_signed};
      mt_pkg::SLTU:   y_o = {31'b0, lt_unsigned};
      mt_pkg::XOR:    y_o = a_i ^ b_i;
      mt_pkg::SRL:    y_o = a_i >> shamt;
      mt_pkg::SRA:    y_o = sra_val;
      mt_pkg::OR:     y_o = a_i | b_i;
      mt_pkg::AND:    y_o = a_i & b_i;
      // LUI carries its upper immediate in b
      mt_pkg::PASS_B: y_o = b_i;
      default:        y_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/barrel_core_top.sv
// Four-thread barrel RV32I integer core with IF, ID, EX and WB stages
`timescale 1ns/1ps
`default_nettype none

module barrel_core_top #(
  parameter int NUM_THREADS         = mt_pkg::NUM_THREADS,
  parameter int THREAD_REGION_WORDS = 64
) (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          run_i,
  input  wire mt_pkg::load_t load_i,
  input  wire logic          load_req_i,
  output logic               load_ack_o,
  output mt_pkg::wb_t        wb_o,
  output logic               wb_valid_o
);

  mt_pkg::tid_t       fetch_tid;
  mt_pkg::imem_addr_t fetch_pc;
  mt_pkg::word_t      fetch_instr;
  mt_pkg::if_id_t     if_id_q;
  mt_pkg::id_ex_t     id_ex_d;
  mt_pkg::id_ex_t     id_ex_q;
  mt_pkg::word_t      alu_y;
  mt_pkg::wb_t        wb_q;
  logic               wb_valid_q;

  // ==================================================
  // IF
  // ==================================================
  thread_pc_bank #(
    .NUM_THREADS         (NUM_THREADS),
    .THREAD_REGION_WORDS (THREAD_REGION_WORDS)
  ) i_pc_bank (
    .clk         (clk),
    .rst         (rst),
    .run_i       (run_i),
    .fetch_tid_o (fetch_tid),
    .fetch_pc_o  (fetch_pc)
  );

  instr_mem i_imem (
    .clk          (clk),
    .rst          (rst),
    .fetch_addr_i (fetch_pc),
    .instr_o      (fetch_instr),
    .load_i       (load_i),
    .load_req_i   (load_req_i),
    .load_ack_o   (load_ack_o)
  );

  // ==================================================
  // ID and EX
  // ==================================================
  decode_unit #(
    .NUM_THREADS (NUM_THREADS)
  ) i_decode (
    .clk        (clk),
    .rst        (rst),
    .if_id_i    (if_id_q),
    .wb_i       (wb_q),
    .wb_valid_i (wb_valid_q),
    .id_ex_o    (id_ex_d)
  );

  alu i_alu (
    .op_i (id_ex_q.alu_op),
    .a_i  (id_ex_q.rs1_val),
    .b_i  (id_ex_q.op_b),
    .y_o  (alu_y)
  );

  // ==================================================
  // Stage registers
  // ==================================================
  always_ff @(posedge clk) begin
    if_id_q.tid   <= fetch_tid;
    if_id_q.instr <= fetch_instr;
    id_ex_q       <= id_ex_d;
    wb_q          <= '{tid: id_ex_q.tid, rd: id_ex_q.rd, data: alu_y};
    if (rst) begin
      if_id_q.valid <= 1'b0;
      id_ex_q.valid <= 1'b0;
      wb_valid_q    <= 1'b0;
    end else begin
      // Idle slots while run_i is low
      if_id_q.valid <= run_i;
      wb_valid_q    <= id_ex_q.valid && id_ex_q.wreg && (id_ex_q.rd != '0);
    end
  end

  assign wb_o       = wb_q;
  assign wb_valid_o = wb_valid_q;

  // Back-to-back writebacks come from back-to-back fetch slots
  a_wb_rotation: assert property (@(posedge clk) disable iff (rst)
    (wb_valid_q ##1 wb_valid_q) |-> (wb_q.tid != $past(wb_q.tid)))
    else $error("wb_o.tid repeated on consecutive writebacks: %0d", wb_q.tid);

endmodule

`default_nettype wire

//--- design/decode_unit.sv
// Instruction decode, operand fetch and ALU control for the ID stage
`timescale 1ns/1ps
`default_nettype none

module decode_unit #(
  parameter int NUM_THREADS = 4
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire mt_pkg::if_id_t  if_id_i,
  input  wire mt_pkg::wb_t     wb_i,
  input  wire logic            wb_valid_i,
  output mt_pkg::id_ex_t       id_ex_o
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  mt_pkg::reg_addr_t rs1;
  mt_pkg::reg_addr_t rs2;
  mt_pkg::reg_addr_t rd;
  mt_pkg::word_t     imm_i;
  mt_pkg::word_t     imm_u;
  mt_pkg::word_t     rs1_data;
  mt_pkg::word_t     rs2_data;
  mt_pkg::alu_op_e   alu_op;
  logic              wreg;

  // ==================================================
  // Fields and immediates
  // ==================================================
  assign opcode = if_id_i.instr[6:0];
  assign rd     = if_id_i.instr[11:7];
  assign funct3 = if_id_i.instr[14:12];
  assign rs1    = if_id_i.instr[19:15];
  assign rs2    = if_id_i.instr[24:20];
  assign funct7 = if_id_i.instr[31:25];

  assign imm_i = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
  assign imm_u = {if_id_i.instr[31:12], 12'b0};

  thread_reg_file #(
    .NUM_THREADS (NUM_THREADS)
  ) i_reg_file (
    .clk        (clk),
    .rst        (rst),
    .rd_tid_i   (if_id_i.tid),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_i       (wb_i),
    .wr_en_i    (wb_valid_i)
  );

  // ==================================================
  // Control
  // ==================================================
  always_comb begin
    alu_op = mt_pkg::ADD;
    wreg   = 1'b1;
    case (opcode)
      mt_pkg::OP_OP, mt_pkg::OP_IMM: begin
        case (funct3)
          // funct7 bit 5 selects SUB only for the register form
          3'b000:  alu_op = (opcode == mt_pkg::OP_OP && funct7[5]) ? mt_pkg::SUB : mt_pkg::ADD;
          3'b001:  alu_op = mt_pkg::SLL;
          3'b010:  alu_op = mt_pkg::SLT;
          3'b011:  alu_op = mt_pkg::SLTU;
          3'b100:  alu_op = mt_pkg::XOR;
          3'b101:  alu_op = funct7[5] ? mt_pkg::SRA : mt_pkg::SRL;
          3'b110:  alu_op = mt_pkg::OR;
          default: alu_op = mt_pkg::AND;
        endcase
      end
      mt_pkg::OP_LUI: alu_op = mt_pkg::PASS_B;
      default:        wreg   = 1'b0;
    endcase
  end

  assign id_ex_o.valid   = if_id_i.valid;
  assign id_ex_o.tid     = if_id_i.tid;
  assign id_ex_o.rd      = rd;
  assign id_ex_o.wreg    = wreg;
  assign id_ex_o.alu_op  = alu_op;
  assign id_ex_o.rs1_val = rs1_data;
  assign id_ex_o.op_b    = (opcode == mt_pkg::OP_IMM) ? imm_i :
                           (opcode == mt_pkg::OP_LUI) ? imm_u : rs2_data;

endmodule

`default_nettype wire

//--- design/instr_mem.sv
// Word-addressed instruction store with a fetch read port and a req/ack load port
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire mt_pkg::imem_addr_t fetch_addr_i,
  output mt_pkg::word_t           instr_o,
  input  wire mt_pkg::load_t      load_i,
  input  wire logic               load_req_i,
  output logic                    load_ack_o
);

  localparam int DEPTH = 2 ** $bits(mt_pkg::imem_addr_t);

  typedef enum logic {
    IDLE,
    ACKED
  } load_state_e;

  mt_pkg::word_t mem [DEPTH];
  load_state_e   state_q;
  logic          wr_en;

  // Empty slots execute as NOPs
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = mt_pkg::NOP_WORD;
    end
  end

  assign instr_o = mem[fetch_addr_i];

  // ==================================================
  // Load handshake
  // ==================================================
  // One write per request, taken on the first req edge
  assign wr_en      = (state_q == IDLE) && load_req_i;
  assign load_ack_o = (state_q == ACKED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (load_req_i) state_q <= ACKED;
        ACKED:   if (!load_req_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[load_i.addr] <= load_i.data;
    end
  end

  // Requester must hold req until it sees ack
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    (load_req_i && !load_ack_o) |=> load_req_i)
    else $error("load_req_i dropped before load_ack_o rose");

endmodule

`default_nettype wire

//--- design/mt_pkg.sv
// Shared widths, opcodes, ALU operation codes and pipeline stage structs
`default_nettype none

package mt_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  parameter int NUM_THREADS = 4;
  parameter int XLEN        = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [1:0]      tid_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [8:0]      imem_addr_t;

  // ==================================================
  // RV32I opcodes handled by the core
  // ==================================================
  localparam logic [6:0] OP_OP  = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_LUI = 7'b0110111;

  // addi x0, x0, 0
  localparam word_t NOP_WORD = 32'h0000_0013;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
  } alu_op_e;

  // ==================================================
  // Stage registers
  // ==================================================
  typedef struct packed {
    logic  valid;
    tid_t  tid;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    tid_t      tid;
    reg_addr_t rd;
    logic      wreg;
    alu_op_e   alu_op;
    word_t     rs1_val;
    word_t     op_b;
  } id_ex_t;

  typedef struct packed {
    tid_t      tid;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  // Instruction load request from the testbench side
  typedef struct packed {
    imem_addr_t addr;
    word_t      data;
  } load_t;

endpackage

`default_nettype wire

//--- design/thread_pc_bank.sv
// Round-robin thread select with one instruction word pointer per thread
`timescale 1ns/1ps
`default_nettype none

module thread_pc_bank #(
  parameter int NUM_THREADS         = 4,
  parameter int THREAD_REGION_WORDS = 64
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               run_i,
  output mt_pkg::tid_t            fetch_tid_o,
  output mt_pkg::imem_addr_t      fetch_pc_o
);

  mt_pkg::tid_t       tid_q;
  mt_pkg::imem_addr_t pc_q [NUM_THREADS];

  assign fetch_tid_o = tid_q;
  assign fetch_pc_o  = pc_q[tid_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      tid_q <= '0;
      // Each thread owns its own slice of instruction memory
      for (int t = 0; t < NUM_THREADS; t++) begin
        pc_q[t] <= mt_pkg::imem_addr_t'(t * THREAD_REGION_WORDS);
      end
    end else if (run_i) begin
      pc_q[tid_q] <= pc_q[tid_q] + 1'b1;
      tid_q       <= (tid_q == mt_pkg::tid_t'(NUM_THREADS - 1)) ? '0 : tid_q + 1'b1;
    end
  end

  a_tid_range: assert property (@(posedge clk) disable iff (rst)
    int'(fetch_tid_o) < NUM_THREADS)
    else $error("fetch_tid_o out of range: %0d", fetch_tid_o);

endmodule

`default_nettype wire

//--- design/thread_reg_file.sv
// Per-thread banks of 32 integer registers, x0 hard-wired to zero
`timescale 1ns/1ps
`default_nettype none

module thread_reg_file #(
  parameter int NUM_THREADS = 4
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire mt_pkg::tid_t      rd_tid_i,
  input  wire mt_pkg::reg_addr_t rs1_i,
  input  wire mt_pkg::reg_addr_t rs2_i,
  output mt_pkg::word_t          rs1_data_o,
  output mt_pkg::word_t          rs2_data_o,
  input  wire mt_pkg::wb_t       wr_i,
  input  wire logic              wr_en_i
);

  mt_pkg::word_t regs [NUM_THREADS][32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        for (int r = 0; r < 32; r++) begin
          regs[t][r] <= '0;
        end
      end
    end else if (wr_en_i && (wr_i.rd != '0)) begin
      regs[wr_i.tid][wr_i.rd] <= wr_i.data;
    end
  end

  // No bypass needed, a thread's previous write is done before it reads again
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rd_tid_i][rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rd_tid_i][rs2_i];

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
design/mt_pkg.sv
design/thread_pc_bank.sv
design/instr_mem.sv
design/thread_reg_file.sv
design/decode_unit.sv
design/alu.sv
design/barrel_core_top.sv
bench/tb_barrel_core.sv
